//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tlu_controller
LOG       ?= sim.log
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
source/tlu_pkg.sv
source/tlu_regs.sv
source/trigger_input.sv
source/trigger_fsm.sv
source/trigger_fifo.sv
source/tlu_controller.sv
tb/tlu_controller_assertions.sv
tb/tb_tlu_controller.sv

//--- source/tlu_controller.sv
// ----------------------------------------
// trigger logic controller top level
// ----------------------------------------
module tlu_controller (
    input  logic                              BUS_CLK,
    input  logic                              RST_SYNC,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [tlu_pkg::bus_adr_width-1:0] wb_adr,
    input  logic [tlu_pkg::bus_dat_width-1:0] wb_dat_i,
    output logic [tlu_pkg::bus_dat_width-1:0] wb_dat_o,
    output logic                              wb_ack,
    input  logic [tlu_pkg::trig_width-1:0]    trigger,
    input  logic [tlu_pkg::trig_width-1:0]    trigger_veto,
    input  logic                              fifo_read,
    output logic                              fifo_empty,
    output logic [31:0]                       fifo_data,
    output logic                              trigger_enabled,
    output logic                              trigger_accepted
);

    logic [tlu_pkg::trig_width-1:0]    trig_select;
    logic [tlu_pkg::trig_width-1:0]    veto_select;
    logic [tlu_pkg::trig_width-1:0]    trig_invert;
    logic [tlu_pkg::bus_dat_width-1:0] count_max;
    logic [tlu_pkg::bus_dat_width-1:0] lost_count;
    logic [tlu_pkg::count_width-1:0]   trig_count;
    logic                              trigger_enable;
    logic                              data_format;
    logic                              soft_trigger_pulse;
    logic                              soft_rst_pulse;
    logic                              trig_edge;
    logic                              veto_active;
    logic                              word_write;
    tlu_pkg::data_word_u               word_data;

    tlu_regs u_regs (
        .BUS_CLK            (BUS_CLK),
        .RST_SYNC           (RST_SYNC),
        .wb_cyc             (wb_cyc),
        .wb_stb             (wb_stb),
        .wb_we              (wb_we),
        .wb_adr             (wb_adr),
        .wb_dat_i           (wb_dat_i),
        .wb_dat_o           (wb_dat_o),
        .wb_ack             (wb_ack),
        .trig_count         (trig_count),
        .lost_count         (lost_count),
        .trig_select        (trig_select),
        .veto_select        (veto_select),
        .trig_invert        (trig_invert),
        .count_max          (count_max),
        .trigger_enable     (trigger_enable),
        .data_format        (data_format),
        .soft_trigger_pulse (soft_trigger_pulse),
        .soft_rst_pulse     (soft_rst_pulse)
    );

    trigger_input u_input (
        .BUS_CLK      (BUS_CLK),
        .RST_SYNC     (RST_SYNC),
        .trigger      (trigger),
        .trigger_veto (trigger_veto),
        .trig_select  (trig_select),
        .veto_select  (veto_select),
        .trig_invert  (trig_invert),
        .trig_edge    (trig_edge),
        .veto_active  (veto_active)
    );

    trigger_fsm u_fsm (
        .BUS_CLK            (BUS_CLK),
        .RST_SYNC           (RST_SYNC),
        .soft_rst_pulse     (soft_rst_pulse),
        .trigger_enable     (trigger_enable),
        .data_format        (data_format),
        .count_max          (count_max),
        .trig_edge          (trig_edge),
        .soft_trigger_pulse (soft_trigger_pulse),
        .veto_active        (veto_active),
        .trigger_enabled    (trigger_enabled),
        .trigger_accepted   (trigger_accepted),
        .trig_count         (trig_count),
        .word_write         (word_write),
        .word_data          (word_data)
    );

    // union word goes in as a plain 32-bit bus
    trigger_fifo u_fifo (
        .BUS_CLK        (BUS_CLK),
        .RST_SYNC       (RST_SYNC),
        .soft_rst_pulse (soft_rst_pulse),
        .word_write     (word_write),
        .word_data      (word_data),
        .fifo_read      (fifo_read),
        .fifo_empty     (fifo_empty),
        .fifo_data      (fifo_data),
        .lost_count     (lost_count)
    );

endmodule

//--- source/tlu_pkg.sv
// ----------------------------------------
// register map, widths and data word type
// ----------------------------------------
package tlu_pkg;

    localparam int trig_width     = 8;
    localparam int bus_adr_width  = 6;
    localparam int bus_dat_width  = 8;
    localparam int count_width    = 32;
    localparam int ts_width       = 16;
    localparam int fifo_depth     = 8;
    localparam int fifo_ptr_width = 3;

    localparam logic [bus_dat_width-1:0] version   = 8'd11;
    localparam logic [bus_dat_width-1:0] reg_reset = 8'h00;  // all config bytes

    // register map, one byte each
    localparam logic [bus_adr_width-1:0] adr_version_rst    = 6'd0;  // write = soft reset
    localparam logic [bus_adr_width-1:0] adr_conf           = 6'd1;
    localparam logic [bus_adr_width-1:0] adr_trig_select    = 6'd2;
    localparam logic [bus_adr_width-1:0] adr_veto_select    = 6'd3;
    localparam logic [bus_adr_width-1:0] adr_trig_invert    = 6'd4;
    localparam logic [bus_adr_width-1:0] adr_trig_count0    = 6'd5;  // lsb
    localparam logic [bus_adr_width-1:0] adr_trig_count1    = 6'd6;
    localparam logic [bus_adr_width-1:0] adr_trig_count2    = 6'd7;
    localparam logic [bus_adr_width-1:0] adr_trig_count3    = 6'd8;
    localparam logic [bus_adr_width-1:0] adr_trig_count_max = 6'd9;  // 0 = no limit
    localparam logic [bus_adr_width-1:0] adr_lost_count     = 6'd10;
    localparam logic [bus_adr_width-1:0] adr_soft_trigger   = 6'd11; // write only

    // conf register bits
    localparam int conf_enable_bit = 0;
    localparam int conf_format_bit = 1;

    localparam logic data_format_counter   = 1'b0;
    localparam logic data_format_timestamp = 1'b1;

    // fifo word, marker always at bit 31
    typedef union packed {
        struct packed {
            logic        marker;
            logic [30:0] count;
        } cnt;
        struct packed {
            logic                marker;
            logic [ts_width-1:0] timestamp;
            logic [14:0]         count_low;
        } ts;
    } data_word_u;

endpackage

//--- source/tlu_regs.sv
// ----------------------------------------
// wishbone slave and configuration registers
// ----------------------------------------
module tlu_regs (
    input  logic                               BUS_CLK,
    input  logic                               RST_SYNC,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [tlu_pkg::bus_adr_width-1:0]  wb_adr,
    input  logic [tlu_pkg::bus_dat_width-1:0]  wb_dat_i,
    output logic [tlu_pkg::bus_dat_width-1:0]  wb_dat_o,
    output logic                               wb_ack,
    input  logic [tlu_pkg::count_width-1:0]    trig_count,
    input  logic [tlu_pkg::bus_dat_width-1:0]  lost_count,
    output logic [tlu_pkg::trig_width-1:0]     trig_select,
    output logic [tlu_pkg::trig_width-1:0]     veto_select,
    output logic [tlu_pkg::trig_width-1:0]     trig_invert,
    output logic [tlu_pkg::bus_dat_width-1:0]  count_max,
    output logic                               trigger_enable,
    output logic                               data_format,
    output logic                               soft_trigger_pulse,
    output logic                               soft_rst_pulse
);

    logic                                    bus_access;
    logic                                    bus_write;
    logic [tlu_pkg::count_width-1:8]         count_snap;  // upper bytes held on byte 0 read
    logic [tlu_pkg::bus_dat_width-1:0]       rd_data;

    // first cycle of a strobe only, ack blocks a second hit
    assign bus_access = wb_cyc && wb_stb && !wb_ack;
    assign bus_write  = bus_access && wb_we;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC)
        begin
            wb_ack             <= 1'b0;
            soft_rst_pulse     <= 1'b0;
            soft_trigger_pulse <= 1'b0;
        end
        else
        begin
            wb_ack             <= bus_access;
            soft_rst_pulse     <= bus_write && (wb_adr == tlu_pkg::adr_version_rst);
            soft_trigger_pulse <= bus_write && (wb_adr == tlu_pkg::adr_soft_trigger);
        end
    end

    // config storage, cleared again by soft reset
    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC || soft_rst_pulse)
        begin
            trigger_enable <= 1'b0;
            data_format    <= tlu_pkg::data_format_counter;
            trig_select    <= tlu_pkg::reg_reset;
            veto_select    <= tlu_pkg::reg_reset;
            trig_invert    <= tlu_pkg::reg_reset;
            count_max      <= tlu_pkg::reg_reset;
            count_snap     <= '0;
        end
        else
        begin
            if (bus_write)
            begin
                case (wb_adr)
                    tlu_pkg::adr_conf:
                    begin
                        trigger_enable <= wb_dat_i[tlu_pkg::conf_enable_bit];
                        data_format    <= wb_dat_i[tlu_pkg::conf_format_bit];
                    end
                    tlu_pkg::adr_trig_select:    trig_select <= wb_dat_i;
                    tlu_pkg::adr_veto_select:    veto_select <= wb_dat_i;
                    tlu_pkg::adr_trig_invert:    trig_invert <= wb_dat_i;
                    tlu_pkg::adr_trig_count_max: count_max   <= wb_dat_i;
                    default: ;  // strobes and read-only
                endcase
            end
            if (bus_access && !wb_we && wb_adr == tlu_pkg::adr_trig_count0)
                count_snap <= trig_count[tlu_pkg::count_width-1:8];
        end
    end

    always_comb
    begin
        case (wb_adr)
            tlu_pkg::adr_version_rst:    rd_data = tlu_pkg::version;
            tlu_pkg::adr_conf:           rd_data = {6'd0, data_format, trigger_enable};
            tlu_pkg::adr_trig_select:    rd_data = trig_select;
            tlu_pkg::adr_veto_select:    rd_data = veto_select;
            tlu_pkg::adr_trig_invert:    rd_data = trig_invert;
            tlu_pkg::adr_trig_count0:    rd_data = trig_count[7:0];  // live byte
            tlu_pkg::adr_trig_count1:    rd_data = count_snap[15:8];
            tlu_pkg::adr_trig_count2:    rd_data = count_snap[23:16];
            tlu_pkg::adr_trig_count3:    rd_data = count_snap[31:24];
            tlu_pkg::adr_trig_count_max: rd_data = count_max;
            tlu_pkg::adr_lost_count:     rd_data = lost_count;
            default:                     rd_data = '0;
        endcase
    end

    // read data lines up with ack
    always_ff @(posedge BUS_CLK)
    begin
        if (bus_access)
            wb_dat_o <= rd_data;
    end

endmodule

//--- source/trigger_fifo.sv
// ----------------------------------------
// show-ahead output fifo, lost word counter
// ----------------------------------------
module trigger_fifo (
    input  logic                              BUS_CLK,
    input  logic                              RST_SYNC,
    input  logic                              soft_rst_pulse,
    input  logic                              word_write,
    input  logic [31:0]                       word_data,
    input  logic                              fifo_read,
    output logic                              fifo_empty,
    output logic [31:0]                       fifo_data,
    output logic [tlu_pkg::bus_dat_width-1:0] lost_count
);

    logic [31:0]                       mem [tlu_pkg::fifo_depth];
    logic [tlu_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [tlu_pkg::fifo_ptr_width-1:0] rd_ptr;
    logic [tlu_pkg::fifo_ptr_width:0]   fill;
    logic                              full;
    logic                              do_write;
    logic                              do_read;

    assign full       = fill == (tlu_pkg::fifo_ptr_width + 1)'(tlu_pkg::fifo_depth);
    assign fifo_empty = fill == '0;
    assign do_write   = word_write && !full;  // full drops the word
    assign do_read    = fifo_read && !fifo_empty;
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= word_data;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC || soft_rst_pulse)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_write && !do_read)
                fill <= fill + 1'b1;
            else if (do_read && !do_write)
                fill <= fill - 1'b1;
            if (word_write && full && lost_count != '1)
                lost_count <= lost_count + 1'b1;  // saturates at 255
        end
    end

endmodule

//--- source/trigger_fsm.sv
// ----------------------------------------
// trigger acceptance, counter and data word
// ----------------------------------------
module trigger_fsm (
    input  logic                              BUS_CLK,
    input  logic                              RST_SYNC,
    input  logic                              soft_rst_pulse,
    input  logic                              trigger_enable,
    input  logic                              data_format,
    input  logic [tlu_pkg::bus_dat_width-1:0] count_max,
    input  logic                              trig_edge,
    input  logic                              soft_trigger_pulse,
    input  logic                              veto_active,
    output logic                              trigger_enabled,
    output logic                              trigger_accepted,
    output logic [tlu_pkg::count_width-1:0]   trig_count,
    output logic                              word_write,
    output tlu_pkg::data_word_u               word_data
);

    logic                              below_limit;
    logic                              can_accept;
    logic                              accept;
    logic [tlu_pkg::count_width-1:0]   count_next;
    logic [tlu_pkg::ts_width-1:0]      timestamp;
    tlu_pkg::data_word_u               next_word;

    // zero max means unlimited
    assign below_limit = (count_max == '0) ||
                         (trig_count < tlu_pkg::count_width'(count_max));
    assign can_accept  = trigger_enable && below_limit;
    assign accept      = (trig_edge || soft_trigger_pulse) && can_accept && !veto_active;
    assign count_next  = trig_count + 1'b1;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC || soft_rst_pulse)
        begin
            trigger_enabled  <= 1'b0;
            trigger_accepted <= 1'b0;
            word_write       <= 1'b0;
            trig_count       <= '0;
            timestamp        <= '0;
        end
        else
        begin
            trigger_enabled  <= can_accept;  // still high in the accept cycle
            trigger_accepted <= accept;
            word_write       <= accept;
            timestamp        <= timestamp + 1'b1;  // free running, wraps
            if (accept)
                trig_count <= count_next;
        end
    end

    always_comb
    begin
        next_word = '0;
        if (data_format == tlu_pkg::data_format_timestamp)
        begin
            next_word.ts.marker    = 1'b1;
            next_word.ts.timestamp = timestamp;
            next_word.ts.count_low = count_next[14:0];
        end
        else
        begin
            next_word.cnt.marker = 1'b1;
            next_word.cnt.count  = count_next[30:0];  // top bit is the marker
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            word_data <= next_word;
    end

endmodule

//--- source/trigger_input.sv
// ----------------------------------------
// trigger and veto masking, edge detect
// ----------------------------------------
module trigger_input (
    input  logic                           BUS_CLK,
    input  logic                           RST_SYNC,
    input  logic [tlu_pkg::trig_width-1:0] trigger,
    input  logic [tlu_pkg::trig_width-1:0] trigger_veto,
    input  logic [tlu_pkg::trig_width-1:0] trig_select,
    input  logic [tlu_pkg::trig_width-1:0] veto_select,
    input  logic [tlu_pkg::trig_width-1:0] trig_invert,
    output logic                           trig_edge,
    output logic                           veto_active
);

    logic       trig_or;
    logic       veto_or;
    logic [1:0] trig_sync;
    logic [1:0] veto_sync;

    assign trig_or = |((trigger ^ trig_invert) & trig_select);
    assign veto_or = |(trigger_veto & veto_select);  // veto has no invert

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC)
        begin
            trig_sync <= 2'b00;
            veto_sync <= 2'b00;
            trig_edge <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[0], trig_or};
            veto_sync <= {veto_sync[0], veto_or};
            trig_edge <= trig_sync[0] && !trig_sync[1];  // rising only
        end
    end

    // second stage aligns with the registered edge
    assign veto_active = veto_sync[1];

endmodule

//--- tb/tb_tlu_controller.sv
// ----------------------------------------
// testbench driven by the golden command file
// ----------------------------------------
module tb_tlu_controller;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    wait_limit  = 40;  // cycles per wait
    localparam int    hold_cycles = 4;
    localparam string golden_path = "tb/tlu_golden.txt";
    localparam logic [31:0] ts_field_mask = 32'h8000_7fff;  // marker and count low

    logic        BUS_CLK = 1'b0;
    logic        RST_SYNC;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [7:0]  wb_dat_i;
    logic [7:0]  wb_dat_o;
    logic        wb_ack;
    logic [7:0]  trigger;
    logic [7:0]  trigger_veto;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        trigger_enabled;
    logic        trigger_accepted;

    int          total_checks;
    int          total_errors;
    int          test_checks;
    int          test_errors;
    string       test_name;
    bit          timed_out;
    bit          have_ts;
    logic [15:0] last_ts;
    int          accept_total;  // trigger_accepted pulses since reset
    int          accept_base;   // pulse total at the last soft reset
    bit          exp_enable;
    logic [7:0]  exp_max;

    tlu_controller u_dut (
        .BUS_CLK          (BUS_CLK),
        .RST_SYNC         (RST_SYNC),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_i         (wb_dat_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack           (wb_ack),
        .trigger          (trigger),
        .trigger_veto     (trigger_veto),
        .fifo_read        (fifo_read),
        .fifo_empty       (fifo_empty),
        .fifo_data        (fifo_data),
        .trigger_enabled  (trigger_enabled),
        .trigger_accepted (trigger_accepted)
    );

    always #4 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK)
    begin
        if (RST_SYNC)
            accept_total <= 0;
        else if (trigger_accepted)
            accept_total <= accept_total + 1;
    end

    task automatic note_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        test_errors++;
        $display("FAIL %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
    endtask

    task automatic note_timeout(input string what);
        test_errors++;
        timed_out = 1'b1;
        $display("test %s: %s did not arrive within %0d cycles", test_name, what, wait_limit);
    endtask

    // one line per finished test
    task automatic close_test();
        if (test_name != "")
            $display("test %-20s %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // enable and limit as last written, soft reset clears them
    task automatic track_write(input logic [5:0] adr, input logic [7:0] dat);
        if (adr == tlu_pkg::adr_version_rst)
        begin
            exp_enable  = 1'b0;
            exp_max     = 8'd0;
            accept_base = accept_total;
        end
        else if (adr == tlu_pkg::adr_conf)
            exp_enable = dat[tlu_pkg::conf_enable_bit];
        else if (adr == tlu_pkg::adr_trig_count_max)
            exp_max = dat;
    endtask

    // accepted pulses follow the count, enable drops at the limit
    task automatic check_trigger_flags(input logic [7:0] exp_count);
        logic exp_enabled;
        exp_enabled = exp_enable && (exp_max == 8'd0 || exp_count < exp_max);
        test_checks++;
        if (accept_total - accept_base != int'(exp_count))
            note_mismatch("trigger_accepted pulses", {24'd0, exp_count},
                          accept_total - accept_base);
        test_checks++;
        if (trigger_enabled !== exp_enabled)
            note_mismatch("trigger_enabled", {31'd0, exp_enabled}, {31'd0, trigger_enabled});
    endtask

    // samples on falling edges, ack holds read data
    task automatic wait_for_ack();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit)
        begin
            @(negedge BUS_CLK);
            seen = wb_ack;
            n++;
        end
        if (!seen)
            note_timeout("bus ack");
    endtask

    task automatic end_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [5:0] adr, input logic [7:0] dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = dat;
        wait_for_ack();
        end_cycle();
    endtask

    task automatic bus_read(input logic [5:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_for_ack();
        data = {24'd0, wb_dat_o};
        end_cycle();
    endtask

    task automatic drive_inputs(input logic [7:0] trig, input logic [7:0] veto);
        trigger      = trig;
        trigger_veto = veto;
        repeat (hold_cycles) @(negedge BUS_CLK);  // covers edge detect latency
    endtask

    task automatic pop_word(output tlu_pkg::data_word_u word, output bit got);
        int n;
        n = 0;
        while (fifo_empty && n < wait_limit)
        begin
            @(negedge BUS_CLK);
            n++;
        end
        got  = !fifo_empty;
        word = fifo_data;  // show-ahead head word
        if (!got)
            note_timeout("fifo word");
        else
        begin
            fifo_read = 1'b1;
            @(negedge BUS_CLK);
            fifo_read = 1'b0;
        end
    endtask

    initial
    begin
        int                  fd;
        int                  gap;
        logic [7:0]          op;
        logic [31:0]         arg_a;
        logic [31:0]         arg_b;
        logic [31:0]         rd_val;
        tlu_pkg::data_word_u exp_word;
        tlu_pkg::data_word_u got_word;
        string               line;
        string               name_buf;
        bit                  got;

        gap          = $urandom(32'h7eb0_e220);  // seeds the generator
        RST_SYNC     = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_i     = '0;
        trigger      = '0;
        trigger_veto = '0;
        fifo_read    = 1'b0;
        total_checks = 0;
        total_errors = 0;
        test_checks  = 0;
        test_errors  = 0;
        test_name    = "";
        timed_out    = 1'b0;
        have_ts      = 1'b0;
        last_ts      = '0;
        accept_base  = 0;
        exp_enable   = 1'b0;
        exp_max      = 8'd0;
        repeat (16) @(negedge BUS_CLK);
        RST_SYNC = 1'b0;
        @(negedge BUS_CLK);

        fd = $fopen(golden_path, "r");
        if (fd == 0)
        begin
            $display("could not open the golden file %s", golden_path);
            test_errors++;
        end
        else
        begin
            while (!timed_out && $fgets(line, fd) > 0)
            begin
                if (line.len() < 2 || line.substr(0, 0) == "#")
                    continue;
                arg_a = '0;
                arg_b = '0;
                void'($sscanf(line, "%c %h %h", op, arg_a, arg_b));
                case (op)
                    "T":
                    begin
                        void'($sscanf(line, "%c %s", op, name_buf));
                        close_test();
                        test_name = name_buf;
                        have_ts   = 1'b0;
                    end
                    "W":
                    begin
                        bus_write(arg_a[5:0], arg_b[7:0]);
                        track_write(arg_a[5:0], arg_b[7:0]);
                    end
                    "R":
                    begin
                        bus_read(arg_a[5:0], rd_val);
                        test_checks++;
                        if (rd_val !== {24'd0, arg_b[7:0]})
                            note_mismatch($sformatf("register %0d", arg_a), arg_b, rd_val);
                        if (arg_a[5:0] == tlu_pkg::adr_trig_count0)
                            check_trigger_flags(arg_b[7:0]);
                    end
                    "I": drive_inputs(arg_a[7:0], arg_b[7:0]);
                    "C":
                    begin
                        exp_word            = '0;
                        exp_word.cnt.marker = 1'b1;
                        exp_word.cnt.count  = arg_a[30:0];
                        pop_word(got_word, got);
                        test_checks++;
                        if (got && got_word !== exp_word)
                            note_mismatch("counter word", exp_word, got_word);
                    end
                    "S":
                    begin
                        exp_word              = '0;
                        exp_word.ts.marker    = 1'b1;
                        exp_word.ts.count_low = arg_a[14:0];
                        pop_word(got_word, got);
                        test_checks++;
                        if (got && (got_word & ts_field_mask) !== exp_word)
                            note_mismatch("timestamp word", exp_word, got_word & ts_field_mask);
                        if (got && have_ts)
                        begin
                            test_checks++;
                            if (got_word.ts.timestamp <= last_ts)
                            begin
                                test_errors++;
                                $display("test %s: timestamp %h is not above the previous %h",
                                         test_name, got_word.ts.timestamp, last_ts);
                            end
                        end
                        if (got)
                        begin
                            last_ts = got_word.ts.timestamp;
                            have_ts = 1'b1;
                        end
                    end
                    "E":
                    begin
                        test_checks++;
                        if (fifo_empty !== 1'b1)
                            note_mismatch("fifo_empty", 32'd1, {31'd0, fifo_empty});
                    end
                    default:
                    begin
                        test_errors++;
                        $display("unknown command in golden file: %s", line);
                    end
                endcase
                gap = 2 + int'($urandom % 4);  // idle between commands
                repeat (gap) @(negedge BUS_CLK);
            end
            $fclose(fd);
        end
        close_test();

        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, u_dut.u_assertions.fail_count);
        if (total_errors == 0 && total_checks > 0 && u_dut.u_assertions.fail_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- tb/tlu_controller_assertions.sv
// ----------------------------------------
// bus and trigger assertions, bound to the top
// ----------------------------------------
module tlu_controller_assertions (
    input logic BUS_CLK,
    input logic RST_SYNC,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic fifo_empty,
    input logic trigger_enabled,
    input logic trigger_accepted
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // failed assertions so far

    ack_after_strobe: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else
        begin
            fail_count++;
            $error("wb_ack without a strobe in the cycle before");
        end

    ack_single_cycle: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
        wb_ack |=> !wb_ack)
        else
        begin
            fail_count++;
            $error("wb_ack held longer than one cycle");
        end

    // both flags registered in the same cycle
    accept_when_enabled: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
        trigger_accepted |-> trigger_enabled)
        else
        begin
            fail_count++;
            $error("trigger accepted while triggering disabled");
        end

    empty_after_reset: assert property (@(posedge BUS_CLK)
        $fell(RST_SYNC) |-> fifo_empty)
        else
        begin
            fail_count++;
            $error("fifo not empty after reset");
        end

endmodule

bind tlu_controller tlu_controller_assertions u_assertions (.*);

//--- tb/tlu_golden.txt
# columns: command, then hex arguments
# T name | W adr data | R adr expect | I trigger veto | C count | S count_low | E
T register_access
R 00 0b
W 02 a5
R 02 a5
W 03 3c
R 03 3c
W 04 0f
R 04 0f
W 09 07
R 09 07
R 0a 00
R 0c 00
R 3f 00
W 01 02
R 01 02
W 00 00
R 02 00
R 01 00
R 09 00
T masking
W 02 02
W 04 02
W 03 01
W 01 01
I 02 00
I 00 00
C 00000001
I 01 00
I 00 00
E
I 02 01
I 00 01
I 00 00
E
R 05 01
R 06 00
T counter_format
W 00 00
W 02 01
W 01 01
I 01 00
I 00 00
I 01 00
I 00 00
I 01 00
I 00 00
C 00000001
C 00000002
C 00000003
E
R 05 03
R 06 00
R 07 00
R 08 00
T limit_soft_trigger
W 00 00
W 09 03
W 01 01
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
C 00000001
C 00000002
C 00000003
E
R 05 03
T timestamp_overflow
W 00 00
W 01 03
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
W 0b 00
R 0a 02
R 05 0a
S 0001
S 0002
S 0003
S 0004
S 0005
S 0006
S 0007
S 0008
E
T soft_reset
W 02 ff
W 0b 00
W 00 00
E
R 05 00
R 0a 00
R 01 00
R 02 00
